// File: hdl/rn_settings.svh
`ifndef RN_SETTINGS_SVH
`define RN_SETTINGS_SVH

// Logical register index width, 32 architectural registers
`define RN_LRF_AW 5

// Physical register index width, 64 physical registers
`define RN_PRF_AW 6

// Instructions renamed per group
`define RN_IW 2

// Instructions retired per cycle
`define RN_CW 2

`endif

// File: hdl/rn_pkg.sv
`default_nettype none

`include "rn_settings.svh"

package rn_pkg;

   localparam int N_LREG = 1 << `RN_LRF_AW;

   typedef logic [`RN_LRF_AW-1:0] lreg_t;
   typedef logic [`RN_PRF_AW-1:0] preg_t;

   // Whole map, one physical index per logical register
   typedef preg_t [N_LREG-1:0] map_tbl_t;

   typedef struct packed {
      lreg_t lrs1;
      lreg_t lrs2;
      lreg_t lrd;
      logic  lrd_we;
   } rn_slot_t;

   // prd is only meaningful when the slot writes lrd
   typedef struct packed {
      preg_t prs1;
      preg_t prs2;
      preg_t prd;
      preg_t pfree;
   } rn_map_t;

   typedef struct packed {
      logic  fire;
      lreg_t lrd;
      preg_t prd;
      preg_t pfree;
      logic  prd_we;
   } cmt_slot_t;

   // Word offsets of the register block
   typedef enum logic [3:0] {
      CSR_CTRL         = 4'd0,
      CSR_FREE_CNT     = 4'd1,
      CSR_RENAME_CNT   = 4'd2,
      CSR_ROLLBACK_CNT = 4'd3
   } csr_addr_t;

endpackage

`default_nettype wire

// File: hdl/rn_map_table.sv
`default_nettype none

`include "rn_settings.svh"

module rn_map_table
#(
   parameter int NUM_WRITE = `RN_IW
)
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic [NUM_WRITE-1:0]          we,
   input  rn_pkg::lreg_t [NUM_WRITE-1:0] waddr,
   input  rn_pkg::preg_t [NUM_WRITE-1:0] wdata,
   input  logic                          restore,
   input  rn_pkg::map_tbl_t              restore_data,
   output rn_pkg::map_tbl_t              table_q
);
   import rn_pkg::*;

   // Identity at reset, restore beats any write
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < N_LREG; i++)
         begin
            table_q[i] <= preg_t'(i);
         end
      end
      else if (restore)
      begin
         table_q <= restore_data;
      end
      else
      begin
         // Later ports are younger, so the last write to an address wins
         for (int w = 0; w < NUM_WRITE; w++)
         begin
            if (we[w])
            begin
               table_q[waddr[w]] <= wdata[w];
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/rn_rat.sv
`default_nettype none

`include "rn_settings.svh"

module rn_rat
(
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              fire,
   input  logic                              rollback,
   input  rn_pkg::rn_slot_t  [`RN_IW-1:0]    slots,
   input  rn_pkg::preg_t     [`RN_IW-1:0]    new_preg,
   input  rn_pkg::cmt_slot_t [`RN_CW-1:0]    cmt,
   output rn_pkg::rn_map_t   [`RN_IW-1:0]    maps
);
   import rn_pkg::*;

   map_tbl_t            spec_tbl;
   map_tbl_t            arch_tbl;

   logic  [`RN_IW-1:0]  spec_we;
   lreg_t [`RN_IW-1:0]  spec_waddr;

   logic  [`RN_CW-1:0]  arch_we;
   lreg_t [`RN_CW-1:0]  arch_waddr;
   preg_t [`RN_CW-1:0]  arch_wdata;

   always_comb
   begin
      for (int i = 0; i < `RN_IW; i++)
      begin
         spec_we[i]    = fire & slots[i].lrd_we;
         spec_waddr[i] = slots[i].lrd;
      end
      for (int k = 0; k < `RN_CW; k++)
      begin
         arch_we[k]    = cmt[k].fire & cmt[k].prd_we;
         arch_waddr[k] = cmt[k].lrd;
         arch_wdata[k] = cmt[k].prd;
      end
   end

   // Speculative map, reloaded from the committed map on rollback
   rn_map_table
      #(
         .NUM_WRITE (`RN_IW)
      )
   spec_map
      (
         .clk          (clk),
         .rst          (rst),
         .we           (spec_we),
         .waddr        (spec_waddr),
         .wdata        (new_preg),
         .restore      (rollback),
         .restore_data (arch_tbl),
         .table_q      (spec_tbl)
      );

   rn_map_table
      #(
         .NUM_WRITE (`RN_CW)
      )
   arch_map
      (
         .clk          (clk),
         .rst          (rst),
         .we           (arch_we),
         .waddr        (arch_waddr),
         .wdata        (arch_wdata),
         .restore      (1'b0),
         .restore_data ('0),
         .table_q      (arch_tbl)
      );

   // Table lookup, then bypass from older slots of the same group
   always_comb
   begin
      for (int i = 0; i < `RN_IW; i++)
      begin
         maps[i].prs1  = spec_tbl[slots[i].lrs1];
         maps[i].prs2  = spec_tbl[slots[i].lrs2];
         maps[i].pfree = spec_tbl[slots[i].lrd];
         maps[i].prd   = new_preg[i];

         // Ascending scan so the youngest older writer wins
         for (int j = 0; j < i; j++)
         begin
            if (slots[j].lrd_we)
            begin
               // RAW on either source
               if (slots[i].lrs1 == slots[j].lrd)
               begin
                  maps[i].prs1 = new_preg[j];
               end
               if (slots[i].lrs2 == slots[j].lrd)
               begin
                  maps[i].prs2 = new_preg[j];
               end
               // WAW, the old mapping is the one just allocated
               if (slots[i].lrd == slots[j].lrd)
               begin
                  maps[i].pfree = new_preg[j];
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/rn_free_list.sv
`default_nettype none

`include "rn_settings.svh"

module rn_free_list
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           fire,
   input  logic                           rollback,
   input  rn_pkg::cmt_slot_t [`RN_CW-1:0] cmt,
   output rn_pkg::preg_t     [`RN_IW-1:0] new_preg,
   output logic              [`RN_PRF_AW:0] free_cnt,
   output logic                           avail
);
   import rn_pkg::*;

   // Registers beyond the identity mapping start out free
   localparam int DEPTH = (1 << `RN_PRF_AW) - N_LREG;
   localparam int IDX_W = $clog2(DEPTH);
   localparam int PTR_W = IDX_W + 1;
   localparam int CNT_W = `RN_PRF_AW + 1;

   preg_t                          ring [DEPTH];

   // Pointers carry one wrap bit above the index
   logic [PTR_W-1:0]               spec_head;
   logic [PTR_W-1:0]               cmt_head;
   logic [PTR_W-1:0]               tail;
   logic [PTR_W-1:0]               fill;

   logic [`RN_CW-1:0]              push_we;
   logic [`RN_CW-1:0][IDX_W-1:0]   push_idx;
   logic [PTR_W-1:0]               push_cnt;

   always_comb
   begin
      for (int i = 0; i < `RN_IW; i++)
      begin
         new_preg[i] = ring[IDX_W'(spec_head + PTR_W'(i))];
      end
   end

   // Fired commit slots pack onto consecutive tail entries
   always_comb
   begin
      logic [PTR_W-1:0] ofs;
      ofs = '0;
      for (int k = 0; k < `RN_CW; k++)
      begin
         push_we[k]  = cmt[k].fire;
         push_idx[k] = IDX_W'(tail + ofs);
         if (cmt[k].fire)
         begin
            ofs = ofs + PTR_W'(1);
         end
      end
      push_cnt = ofs;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         spec_head <= '0;
         cmt_head  <= '0;
         tail      <= PTR_W'(DEPTH);
         for (int i = 0; i < DEPTH; i++)
         begin
            ring[i] <= preg_t'(N_LREG + i);
         end
      end
      else
      begin
         if (rollback)
         begin
            spec_head <= cmt_head;
         end
         else if (fire)
         begin
            spec_head <= spec_head + PTR_W'(`RN_IW);
         end
         cmt_head <= cmt_head + push_cnt;
         tail     <= tail + push_cnt;
         for (int k = 0; k < `RN_CW; k++)
         begin
            if (push_we[k])
            begin
               ring[push_idx[k]] <= cmt[k].pfree;
            end
         end
      end
   end

   assign fill     = tail - spec_head;
   assign free_cnt = CNT_W'(fill);
   assign avail    = free_cnt >= CNT_W'(`RN_IW);

endmodule

`default_nettype wire

// File: hdl/rn_csr.sv
`default_nettype none

`include "rn_settings.svh"

module rn_csr
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic [3:0]            wb_adr,
   input  logic [31:0]           wb_dat_i,
   output logic [31:0]           wb_dat_o,
   output logic                  wb_ack,
   input  logic [`RN_PRF_AW:0]   free_cnt,
   input  logic                  fire,
   input  logic [`RN_IW-1:0]     slots_we,
   input  logic                  rollback,
   output logic                  rename_en
);
   import rn_pkg::*;

   logic        wb_req;
   logic [31:0] rename_cnt;
   logic [31:0] rollback_cnt;
   logic [31:0] ren_inc;

   // New request only while no ack is out, so ack lasts one cycle
   assign wb_req = wb_cyc & wb_stb & ~wb_ack;

   always_comb
   begin
      ren_inc = '0;
      for (int i = 0; i < `RN_IW; i++)
      begin
         ren_inc = ren_inc + 32'(slots_we[i]);
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wb_ack       <= 1'b0;
         rename_en    <= 1'b0;
         rename_cnt   <= '0;
         rollback_cnt <= '0;
      end
      else
      begin
         wb_ack <= wb_req;
         // Only CTRL is writable
         if (wb_req && wb_we && wb_adr == CSR_CTRL)
         begin
            rename_en <= wb_dat_i[0];
         end
         if (fire)
         begin
            rename_cnt <= rename_cnt + ren_inc;
         end
         if (rollback)
         begin
            rollback_cnt <= rollback_cnt + 32'd1;
         end
      end
   end

   // Read data lands together with the ack
   always_ff @(posedge clk)
   begin
      if (wb_req)
      begin
         case (wb_adr)
            CSR_CTRL:         wb_dat_o <= {31'd0, rename_en};
            CSR_FREE_CNT:     wb_dat_o <= 32'(free_cnt);
            CSR_RENAME_CNT:   wb_dat_o <= rename_cnt;
            CSR_ROLLBACK_CNT: wb_dat_o <= rollback_cnt;
            default:          wb_dat_o <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/rn_top.sv
`default_nettype none

`include "rn_settings.svh"

module rn_top
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           rn_valid,
   input  rn_pkg::rn_slot_t  [`RN_IW-1:0] rn_slots,
   output logic                           rn_ready,
   output rn_pkg::rn_map_t   [`RN_IW-1:0] rn_maps,
   input  rn_pkg::cmt_slot_t [`RN_CW-1:0] cmt,
   input  logic                           rollback,
   input  logic                           wb_cyc,
   input  logic                           wb_stb,
   input  logic                           wb_we,
   input  logic [3:0]                     wb_adr,
   input  logic [31:0]                    wb_dat_i,
   output logic [31:0]                    wb_dat_o,
   output logic                           wb_ack
);
   import rn_pkg::*;

   logic                 fire;
   logic                 rename_en;
   logic                 avail;
   preg_t [`RN_IW-1:0]   new_preg;
   logic  [`RN_PRF_AW:0] free_cnt;
   logic  [`RN_IW-1:0]   slots_we;

   // A whole group needs RN_IW free registers, and nothing renames during rollback
   assign rn_ready = rename_en & avail & ~rollback;
   assign fire     = rn_valid & rn_ready;

   always_comb
   begin
      for (int i = 0; i < `RN_IW; i++)
      begin
         slots_we[i] = rn_slots[i].lrd_we;
      end
   end

   rn_rat rn_rat_i
      (
         .clk      (clk),
         .rst      (rst),
         .fire     (fire),
         .rollback (rollback),
         .slots    (rn_slots),
         .new_preg (new_preg),
         .cmt      (cmt),
         .maps     (rn_maps)
      );

   rn_free_list rn_free_list_i
      (
         .clk      (clk),
         .rst      (rst),
         .fire     (fire),
         .rollback (rollback),
         .cmt      (cmt),
         .new_preg (new_preg),
         .free_cnt (free_cnt),
         .avail    (avail)
      );

   rn_csr rn_csr_i
      (
         .clk       (clk),
         .rst       (rst),
         .wb_cyc    (wb_cyc),
         .wb_stb    (wb_stb),
         .wb_we     (wb_we),
         .wb_adr    (wb_adr),
         .wb_dat_i  (wb_dat_i),
         .wb_dat_o  (wb_dat_o),
         .wb_ack    (wb_ack),
         .free_cnt  (free_cnt),
         .fire      (fire),
         .slots_we  (slots_we),
         .rollback  (rollback),
         .rename_en (rename_en)
      );

endmodule

`default_nettype wire

// File: verif/rn_props.sv
`default_nettype none

`include "rn_settings.svh"

module rn_props
(
   input logic                           clk,
   input logic                           rst,
   input logic                           rn_ready,
   input logic                           fire,
   input logic                           rollback,
   input logic                           wb_cyc,
   input logic                           wb_stb,
   input logic                           wb_ack,
   input rn_pkg::rn_map_t   [`RN_IW-1:0] rn_maps,
   input rn_pkg::cmt_slot_t [`RN_CW-1:0] cmt
);
   timeunit 1ns;
   timeprecision 100ps;
   import rn_pkg::*;

   // Ack one cycle after a fresh request, and only for one cycle
   ack_follows_req: assert property (@(posedge clk) disable iff (rst)
      wb_cyc && wb_stb && !wb_ack |=> wb_ack)
      else $error("Wishbone ack missing after request");

   ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
      wb_ack |=> !wb_ack)
      else $error("Wishbone ack held longer than one cycle");

   no_ready_in_rollback: assert property (@(posedge clk) disable iff (rst)
      rollback |-> !rn_ready)
      else $error("rn_ready high during rollback");

   no_commit_in_rollback: assert property (@(posedge clk) disable iff (rst)
      rollback |-> !(cmt[0].fire || cmt[1].fire))
      else $error("Commit fired during rollback");

   distinct_new_regs: assert property (@(posedge clk) disable iff (rst)
      fire |-> rn_maps[0].prd != rn_maps[1].prd)
      else $error("Same physical register allocated twice in one group");

endmodule

bind rn_top rn_props rn_props_i
   (
      .clk      (clk),
      .rst      (rst),
      .rn_ready (rn_ready),
      .fire     (fire),
      .rollback (rollback),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_ack   (wb_ack),
      .rn_maps  (rn_maps),
      .cmt      (cmt)
   );

`default_nettype wire

// File: verif/rn_tb.sv
`default_nettype none

`include "rn_settings.svh"

module rn_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import rn_pkg::*;

   localparam int WAIT_MAX   = 20;
   localparam int FREE_DEPTH = (1 << `RN_PRF_AW) - N_LREG;

   logic                   clk = 1'b0;
   logic                   rst;
   logic                   rn_valid;
   rn_slot_t  [`RN_IW-1:0] rn_slots;
   logic                   rn_ready;
   rn_map_t   [`RN_IW-1:0] rn_maps;
   cmt_slot_t [`RN_CW-1:0] cmt;
   logic                   rollback;
   logic                   wb_cyc;
   logic                   wb_stb;
   logic                   wb_we;
   logic [3:0]             wb_adr;
   logic [31:0]            wb_dat_i;
   logic [31:0]            wb_dat_o;
   logic                   wb_ack;

   // Reference model of both maps and the free list
   map_tbl_t               spec_m;
   map_tbl_t               arch_m;
   // Entries from the committed head to the tail
   preg_t                  fq[$];
   // Allocations past the committed head
   int                     spec_ofs;
   // In-flight slots in program order, standing in for the ROB
   cmt_slot_t              rob[$];
   int                     ren_cnt;
   int                     rb_cnt;

   logic [31:0]            rng_state = 32'he98b_47dc;
   int                     checks;
   int                     errors;
   int                     test_err;

   rn_top rn_top_i (.*);

   always #50 clk = ~clk;

   function automatic logic [31:0] rand_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = rand_next();
      return int'(r[30:8]) % n;
   endfunction

   function automatic rn_slot_t rand_slot();
      rn_slot_t s;
      s.lrs1   = lreg_t'(rand_below(N_LREG));
      s.lrs2   = lreg_t'(rand_below(N_LREG));
      s.lrd    = lreg_t'(rand_below(N_LREG));
      s.lrd_we = rand_below(4) != 0;
      return s;
   endfunction

   function automatic int model_free();
      return fq.size() - spec_ofs;
   endfunction

   task automatic check_val(input string name, input int got, input int exp);
      checks++;
      if (got != exp)
      begin
         errors++;
         $display("FAILED %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic report_test(input string name);
      $display("test %-22s %0d errors", name, errors - test_err);
      test_err = errors;
   endtask

   task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int  n;
      bit  got;
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_i <= wdat;
      got  = 0;
      n    = 0;
      rdat = '0;
      while (!got && n < WAIT_MAX)
      begin
         @(negedge clk);
         if (wb_ack)
         begin
            got  = 1;
            rdat = wb_dat_o;
         end
         n++;
      end
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      if (!got)
      begin
         errors++;
         $display("Wishbone access to offset %0d got no ack within %0d cycles", adr, WAIT_MAX);
      end
   endtask

   // Present one group, wait for rn_ready, then check every slot against the model
   task automatic rename_group(input rn_slot_t s0, input rn_slot_t s1);
      rn_slot_t [`RN_IW-1:0] grp;
      cmt_slot_t             c;
      int                    n;
      bit                    fired;
      grp[0] = s0;
      grp[1] = s1;
      @(posedge clk);
      rn_valid <= 1'b1;
      rn_slots <= grp;
      fired = 0;
      n     = 0;
      while (!fired && n < WAIT_MAX)
      begin
         @(negedge clk);
         if (rn_ready)
         begin
            fired = 1;
            for (int i = 0; i < `RN_IW; i++)
            begin
               c.fire   = 1'b1;
               c.lrd    = grp[i].lrd;
               c.prd    = fq[spec_ofs % fq.size()];
               c.prd_we = grp[i].lrd_we;
               // A slot that writes nothing hands its new register back at commit
               c.pfree  = grp[i].lrd_we ? spec_m[grp[i].lrd] : c.prd;
               check_val($sformatf("rn_maps[%0d].prs1", i), int'(rn_maps[i].prs1),
                         int'(spec_m[grp[i].lrs1]));
               check_val($sformatf("rn_maps[%0d].prs2", i), int'(rn_maps[i].prs2),
                         int'(spec_m[grp[i].lrs2]));
               check_val($sformatf("rn_maps[%0d].prd", i), int'(rn_maps[i].prd), int'(c.prd));
               check_val($sformatf("rn_maps[%0d].pfree", i), int'(rn_maps[i].pfree),
                         int'(spec_m[grp[i].lrd]));
               // Sequential update gives the younger slot the bypassed view
               if (grp[i].lrd_we)
               begin
                  spec_m[grp[i].lrd] = c.prd;
                  ren_cnt++;
               end
               spec_ofs++;
               rob.push_back(c);
            end
         end
         n++;
      end
      @(posedge clk);
      rn_valid <= 1'b0;
      if (!fired)
      begin
         errors++;
         $display("Rename group not accepted within %0d cycles", WAIT_MAX);
      end
   endtask

   task automatic commit_oldest(input int n);
      cmt_slot_t [`RN_CW-1:0] c;
      c = '0;
      for (int k = 0; k < n && k < `RN_CW && rob.size() > 0; k++)
      begin
         c[k] = rob.pop_front();
         if (c[k].prd_we)
         begin
            arch_m[c[k].lrd] = c[k].prd;
         end
         fq.delete(0);
         fq.push_back(c[k].pfree);
         spec_ofs--;
      end
      @(posedge clk);
      cmt <= c;
      @(posedge clk);
      cmt <= '0;
   endtask

   task automatic commit_some();
      int n;
      n = rand_below(3);
      if (model_free() < `RN_IW)
      begin
         n = 2;
      end
      if (n > 0)
      begin
         commit_oldest(n);
      end
   endtask

   task automatic do_rollback();
      @(posedge clk);
      rollback <= 1'b1;
      @(negedge clk);
      check_val("rn_ready", int'(rn_ready), 0);
      @(posedge clk);
      rollback <= 1'b0;
      spec_m   = arch_m;
      spec_ofs = 0;
      rob.delete();
      rb_cnt++;
   endtask

   initial
   begin
      rn_slot_t    s0;
      rn_slot_t    s1;
      lreg_t       r;
      logic [31:0] rd;
      int          n;

      rst      <= 1'b1;
      rn_valid <= 1'b0;
      rn_slots <= '0;
      cmt      <= '0;
      rollback <= 1'b0;
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
      wb_adr   <= '0;
      wb_dat_i <= '0;
      checks   = 0;
      errors   = 0;
      test_err = 0;
      ren_cnt  = 0;
      rb_cnt   = 0;
      spec_ofs = 0;
      for (int i = 0; i < N_LREG; i++)
      begin
         spec_m[i] = preg_t'(i);
         arch_m[i] = preg_t'(i);
      end
      for (int i = 0; i < FREE_DEPTH; i++)
      begin
         fq.push_back(preg_t'(N_LREG + i));
      end

      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_val("rn_ready", int'(rn_ready), 0);
      check_val("wb_ack", int'(wb_ack), 0);

      // Test 1: reset state, enable bit and identity lookup
      wb_access(1'b0, CSR_FREE_CNT, '0, rd);
      check_val("FREE_CNT", int'(rd), model_free());
      wb_access(1'b0, CSR_CTRL, '0, rd);
      check_val("CTRL", int'(rd), 0);
      repeat (3)
      begin
         @(negedge clk);
         check_val("rn_ready", int'(rn_ready), 0);
      end
      wb_access(1'b1, CSR_CTRL, 32'd1, rd);
      wb_access(1'b0, CSR_CTRL, '0, rd);
      check_val("CTRL", int'(rd), 1);
      rename_group(rand_slot(), rand_slot());
      rename_group(rand_slot(), rand_slot());
      report_test("reset_and_enable");

      // Test 2: groups without intra-group hazards
      for (int g = 0; g < 40; g++)
      begin
         s0 = rand_slot();
         s1 = rand_slot();
         if (s0.lrd_we)
         begin
            if (s1.lrs1 == s0.lrd)
               s1.lrs1 = s1.lrs1 + lreg_t'(1);
            if (s1.lrs2 == s0.lrd)
               s1.lrs2 = s1.lrs2 + lreg_t'(1);
            if (s1.lrd == s0.lrd)
               s1.lrd = s1.lrd + lreg_t'(1);
         end
         rename_group(s0, s1);
         commit_some();
      end
      report_test("random_groups");

      // Test 3: slot 1 reads or rewrites what slot 0 writes
      for (int g = 0; g < 24; g++)
      begin
         r         = lreg_t'(rand_below(N_LREG));
         s0        = rand_slot();
         s0.lrd    = r;
         s0.lrd_we = 1'b1;
         s1        = rand_slot();
         n         = rand_below(3);
         if (n != 1)
            s1.lrs1 = r;
         if (n != 0)
            s1.lrs2 = r;
         s1.lrd = r;
         rename_group(s0, s1);
         commit_some();
      end
      report_test("intra_group_bypass");

      // Test 4: partial commits, then rollback to the architectural map
      for (int k = 0; k < 3; k++)
      begin
         for (int g = 0; g < 4; g++)
         begin
            if (model_free() < `RN_IW)
               commit_oldest(2);
            rename_group(rand_slot(), rand_slot());
         end
         n = rand_below(rob.size());
         while (n > 0)
         begin
            commit_oldest(n > 1 ? 2 : 1);
            n = n - 2;
         end
         wb_access(1'b0, CSR_FREE_CNT, '0, rd);
         check_val("FREE_CNT", int'(rd), model_free());
         do_rollback();
         wb_access(1'b0, CSR_FREE_CNT, '0, rd);
         check_val("FREE_CNT", int'(rd), model_free());
      end
      rename_group(rand_slot(), rand_slot());
      report_test("commit_and_rollback");

      // Test 5: drain the free list with no commits
      n = 0;
      while (model_free() >= `RN_IW && n < 40)
      begin
         rename_group(rand_slot(), rand_slot());
         n++;
      end
      @(negedge clk);
      check_val("rn_ready", int'(rn_ready), 0);
      wb_access(1'b0, CSR_FREE_CNT, '0, rd);
      check_val("FREE_CNT", int'(rd), model_free());
      commit_oldest(2);
      @(negedge clk);
      check_val("rn_ready", int'(rn_ready), 1);
      rename_group(rand_slot(), rand_slot());
      report_test("free_list_empty");

      // Test 6: event counters
      wb_access(1'b0, CSR_RENAME_CNT, '0, rd);
      check_val("RENAME_CNT", int'(rd), ren_cnt);
      wb_access(1'b0, CSR_ROLLBACK_CNT, '0, rd);
      check_val("ROLLBACK_CNT", int'(rd), rb_cnt);
      report_test("event_counters");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display("*** PASSED ***");
      end
      else
      begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hdl
hdl/rn_pkg.sv
hdl/rn_map_table.sv
hdl/rn_rat.sv
hdl/rn_free_list.sv
hdl/rn_csr.sv
hdl/rn_top.sv
verif/rn_props.sv
verif/rn_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = rn_tb
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
